// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_pic_core
FLIST     := flist.f
LOG       := sim.log
BUILD     := obj_dir
BIN       := $(BUILD)/V$(TOP)
SRCS      := $(filter %.sv,$(shell cat $(FLIST))) pic_defs.svh

.PHONY: all run lint clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Checks failed" $(LOG) || ! grep -q "All checks passed" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@echo "Simulation passed"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== flist.f ====
+incdir+.
pic_types_pkg.sv
pic_ctrl_pkg.sv
pic_source_select.sv
pic_handshake_fsm.sv
pic_core.sv
tb_pic_core.sv

// ==== pic_core.sv ====
`default_nettype none

module pic_core (
    input  wire logic                       clk_in,
    input  wire logic                       rst_in,
    input  wire pic_types_pkg::src_vec_t    intr_rq,          // Level requests.
    input  wire pic_ctrl_pkg::intr_mode_t   intr_mode,        // Mode command.
    input  wire pic_types_pkg::prio_table_t priorities_table, // Read at capture.
    input  wire logic                       intr_in,          // Strobe, idle high.
    input  wire pic_types_pkg::intr_word_t  intr_ack_bus,     // Done word.
    output logic                            intr_out,         // Interrupt to the processor.
    output pic_types_pkg::intr_word_t       intr_bus          // Code and id of the source.
);

    import pic_types_pkg::*;
    import pic_ctrl_pkg::*;

    intr_mode_t  mode;          // Captured mode.
    sel_result_t sel_result;    // Search result to the sequencer.
    logic        load_table;
    logic        clear_index;
    logic        step;

    ////////////////////
    // Source search.
    ////////////////////

    pic_source_select u_source_select (
        .clk_in           (clk_in),
        .rst_in           (rst_in),
        .mode             (mode),
        .intr_rq          (intr_rq),
        .priorities_table (priorities_table),
        .load_table       (load_table),
        .clear_index      (clear_index),
        .step             (step),
        .sel_result       (sel_result)
    );

    ////////////////////
    // Handshake.
    ////////////////////

    pic_handshake_fsm u_handshake_fsm (
        .clk_in        (clk_in),
        .rst_in        (rst_in),
        .intr_mode_cmd (intr_mode),
        .sel_result    (sel_result),
        .intr_in       (intr_in),
        .intr_ack_bus  (intr_ack_bus),
        .mode          (mode),
        .load_table    (load_table),
        .clear_index   (clear_index),
        .step          (step),
        .intr_out      (intr_out),
        .intr_bus      (intr_bus)
    );

endmodule

`default_nettype wire

// ==== pic_ctrl_pkg.sv ====
`default_nettype none

package pic_ctrl_pkg;

    ////////////////////
    // Mode command.
    ////////////////////

    // Level on intr_mode, only POLL and PRIO get captured.
    typedef enum logic [1:0] {
        MODE_NONE = 2'b00,  // No command yet.
        MODE_POLL = 2'b01,  // Round robin, one source a clock.
        MODE_PRIO = 2'b10,  // Ranked by the loaded table.
        MODE_BAD  = 2'b11   // Not a valid command.
    } intr_mode_t;

    ////////////////////
    // Sequencer state.
    ////////////////////

    typedef enum logic [2:0] {
        ST_RESET,           // One cycle after reset.
        ST_GET_MODE,        // Wait for a valid mode command.
        ST_ARM,             // Clear the polling index.
        ST_SCAN,            // Look for a source to serve.
        ST_SEND_ID,         // intr_out high, wait for first strobe.
        ST_WAIT_ID_ACK,     // Word is out, wait for its acknowledge.
        ST_WAIT_DONE        // Wait for the done word.
    } pic_state_t;

endpackage

`default_nettype wire

// ==== pic_defs.svh ====
`ifndef PIC_DEFS_SVH
`define PIC_DEFS_SVH

////////////////////
// Source geometry.
////////////////////

// Number of interrupt request lines.
`define PIC_NUM_SRC 8

// Bits needed to name one source.
`define PIC_ID_W 3

// Width of a word on intr_bus and intr_ack_bus.
`define PIC_BUS_W 8

// The condition code fills what the id leaves of a bus word.
`define PIC_CODE_W (`PIC_BUS_W - `PIC_ID_W)

////////////////////
// Protocol codes.
////////////////////

// Sent with the id once the processor takes a polled interrupt.
`define PIC_CODE_POLL_TX 5'b01011

// Sent with the id once the processor takes a priority interrupt.
`define PIC_CODE_PRIO_TX 5'b10011

// Expected from the processor when a polled routine finishes.
`define PIC_CODE_POLL_DONE 5'b10100

// Expected from the processor when a priority routine finishes.
`define PIC_CODE_PRIO_DONE 5'b01100

`endif

// ==== pic_handshake_fsm.sv ====
`default_nettype none

`include "pic_defs.svh"

module pic_handshake_fsm (
    input  wire logic                      clk_in,
    input  wire logic                      rst_in,
    input  wire pic_ctrl_pkg::intr_mode_t  intr_mode_cmd,    // Mode command from outside.
    input  wire pic_types_pkg::sel_result_t sel_result,      // Search result.
    input  wire logic                      intr_in,          // Processor strobe, active low.
    input  wire pic_types_pkg::intr_word_t intr_ack_bus,     // Done word from the processor.
    output pic_ctrl_pkg::intr_mode_t       mode,             // Captured mode.
    output logic                           load_table,
    output logic                           clear_index,
    output logic                           step,
    output logic                           intr_out,
    output pic_types_pkg::intr_word_t      intr_bus
);

    import pic_types_pkg::*;
    import pic_ctrl_pkg::*;

    pic_state_t state_q, state_d;       // Sequencer state.
    intr_mode_t mode_q, mode_d;         // Captured once per reset.
    src_id_t    id_q, id_d;             // Source in service.
    logic       intr_out_q, intr_out_d;
    intr_word_t intr_bus_q, intr_bus_d;
    cond_code_t tx_code;                // Code sent with the id.
    cond_code_t done_code;              // Code expected back.
    intr_word_t done_word;              // Full word that ends service.
    logic       strobe;                 // Processor pulled intr_in low.

    ////////////////////
    // Codes per mode.
    ////////////////////

    assign tx_code   = (mode_q == MODE_PRIO) ? `PIC_CODE_PRIO_TX : `PIC_CODE_POLL_TX;
    assign done_code = (mode_q == MODE_PRIO) ? `PIC_CODE_PRIO_DONE : `PIC_CODE_POLL_DONE;
    assign done_word = intr_word_t'{code: done_code, id: id_q};
    assign strobe    = ~intr_in;

    ////////////////////
    // Next state.
    ////////////////////

    always_comb begin
        state_d    = state_q;   // Every state holds by default.
        mode_d     = mode_q;
        id_d       = id_q;
        intr_out_d = intr_out_q;
        intr_bus_d = intr_bus_q;

        case (state_q)
            ST_RESET: begin
                state_d = ST_GET_MODE;
            end

            // Only 01 and 10 are taken, anything else keeps waiting.
            ST_GET_MODE: begin
                if (intr_mode_cmd == MODE_POLL || intr_mode_cmd == MODE_PRIO) begin
                    mode_d  = intr_mode_cmd;
                    state_d = ST_ARM;
                end
            end

            ST_ARM: begin
                state_d = ST_SCAN;  // Index clears here.
            end

            // Raise the interrupt and remember who asked.
            ST_SCAN: begin
                if (sel_result.hit) begin
                    intr_out_d = 1'b1;
                    id_d       = sel_result.id;
                    state_d    = ST_SEND_ID;
                end
            end

            // First low: drop the line and put the word out.
            ST_SEND_ID: begin
                if (strobe) begin
                    intr_out_d = 1'b0;
                    intr_bus_d = intr_word_t'{code: tx_code, id: id_q};
                    state_d    = ST_WAIT_ID_ACK;
                end
            end

            ST_WAIT_ID_ACK: begin
                if (strobe) begin
                    state_d = ST_WAIT_DONE; // Word acknowledged.
                end
            end

            // A wrong word is ignored, we keep waiting.
            ST_WAIT_DONE: begin
                if (strobe && intr_ack_bus == done_word) begin
                    state_d = ST_SCAN;
                end
            end
        endcase
    end

    ////////////////////
    // Registers.
    ////////////////////

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            state_q    <= ST_RESET;
            mode_q     <= MODE_NONE;
            id_q       <= '0;
            intr_out_q <= 1'b0;
            intr_bus_q <= '0;       // Bus reads zero until the first service.
        end else begin
            state_q    <= state_d;
            mode_q     <= mode_d;
            id_q       <= id_d;
            intr_out_q <= intr_out_d;
            intr_bus_q <= intr_bus_d;
        end
    end

    ////////////////////
    // Outputs.
    ////////////////////

    assign mode        = mode_q;
    assign load_table  = (state_q == ST_GET_MODE) && (intr_mode_cmd == MODE_PRIO);
    assign clear_index = (state_q == ST_ARM);
    assign step        = (state_q == ST_SCAN) && !sel_result.hit; // Miss, look further.
    assign intr_out    = intr_out_q;
    assign intr_bus    = intr_bus_q;

    ////////////////////
    // Checks.
    ////////////////////

    // The line is up only while the first strobe is awaited.
    a_out_in_send: assert property (
        @(posedge clk_in) disable iff (rst_in)
        intr_out |-> state_q == ST_SEND_ID
    );

    // A table load happens only before capture and leads into priority mode.
    a_load_at_capture: assert property (
        @(posedge clk_in) disable iff (rst_in)
        load_table |-> (mode_q == MODE_NONE) ##1 (state_q == ST_ARM && mode_q == MODE_PRIO)
    );

endmodule

`default_nettype wire

// ==== pic_source_select.sv ====
`default_nettype none

`include "pic_defs.svh"

module pic_source_select (
    input  wire logic                      clk_in,
    input  wire logic                      rst_in,
    input  wire pic_ctrl_pkg::intr_mode_t  mode,             // Captured mode.
    input  wire pic_types_pkg::src_vec_t   intr_rq,          // Level requests.
    input  wire pic_types_pkg::prio_table_t priorities_table,
    input  wire logic                      load_table,       // Take the table this cycle.
    input  wire logic                      clear_index,      // Restart polling at source 0.
    input  wire logic                      step,             // Move to the next source.
    output pic_types_pkg::sel_result_t     sel_result
);

    import pic_types_pkg::*;
    import pic_ctrl_pkg::*;

    src_id_t     poll_idx_q;    // Source checked this cycle in polling mode.
    prio_table_t prio_table_q;  // Ranking, entry 0 highest.
    sel_result_t poll_sel;      // Polling candidate.
    sel_result_t prio_sel;      // Priority candidate.

    ////////////////////
    // Polling index.
    ////////////////////

    // Only advances on a miss, so a source that stays active
    // is found again right after its service.
    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            poll_idx_q <= '0;
        end else if (clear_index) begin
            poll_idx_q <= '0;
        end else if (step) begin
            poll_idx_q <= src_id_t'(poll_idx_q + 1'b1); // Wraps from 7 to 0.
        end
    end

    ////////////////////
    // Priority table.
    ////////////////////

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            prio_table_q <= '0;
        end else if (load_table) begin
            prio_table_q <= priorities_table;   // Held until the next reset.
        end
    end

    ////////////////////
    // Search.
    ////////////////////

    // Polling looks at one line only.
    always_comb begin
        poll_sel.hit = intr_rq[poll_idx_q];
        poll_sel.id  = poll_idx_q;
    end

    // Walk the table from the lowest rank up.
    // A later match overwrites, so entry 0 wins.
    always_comb begin
        prio_sel = '0;
        for (int i = `PIC_NUM_SRC - 1; i >= 0; i--) begin
            if (intr_rq[prio_table_q[i]]) begin
                prio_sel.hit = 1'b1;
                prio_sel.id  = prio_table_q[i];
            end
        end
    end

    // Nothing is reported before a mode is captured.
    always_comb begin
        case (mode)
            MODE_POLL: sel_result = poll_sel;
            MODE_PRIO: sel_result = prio_sel;
            default:   sel_result = '0;
        endcase
    end

    ////////////////////
    // Checks.
    ////////////////////

    // A hit must name a line that is requesting.
    a_hit_is_request: assert property (
        @(posedge clk_in) disable iff (rst_in)
        sel_result.hit |-> intr_rq[sel_result.id]
    );

endmodule

`default_nettype wire

// ==== pic_types_pkg.sv ====
`default_nettype none

`include "pic_defs.svh"

package pic_types_pkg;

    ////////////////////
    // Plain vectors.
    ////////////////////

    typedef logic [`PIC_ID_W-1:0]    src_id_t;      // Number of one source.
    typedef logic [`PIC_NUM_SRC-1:0] src_vec_t;     // One request bit per source.
    typedef logic [`PIC_CODE_W-1:0]  cond_code_t;   // Condition code of a bus word.

    ////////////////////
    // Composite types.
    ////////////////////

    // Word on intr_bus and intr_ack_bus.
    // Code sits in the upper bits, the id in the lower ones.
    typedef struct packed {
        cond_code_t code;   // Tx or done code.
        src_id_t    id;     // Source the word refers to.
    } intr_word_t;

    // Priority ranking, entry 0 in the low bits is served first.
    typedef src_id_t [`PIC_NUM_SRC-1:0] prio_table_t;

    // What the source search found this cycle.
    typedef struct packed {
        logic    hit;       // A source is ready for service.
        src_id_t id;        // Which one, valid with hit.
    } sel_result_t;

endpackage

`default_nettype wire

// ==== tb_pic_core.sv ====
`default_nettype none

`include "pic_defs.svh"

module tb_pic_core;

    timeunit 1ns;
    timeprecision 100ps;

    import pic_types_pkg::*;
    import pic_ctrl_pkg::*;

    logic        clk_in;
    logic        rst_in;
    src_vec_t    intr_rq;
    intr_mode_t  intr_mode;
    prio_table_t priorities_table;
    logic        intr_in;           // Idles high.
    intr_word_t  intr_ack_bus;
    logic        intr_out;
    intr_word_t  intr_bus;

    prio_table_t tbl;                   // Ranking the DUT captured.
    logic [31:0] lcg_state = 32'd29;    // LCG seed.
    int          errors = 0;
    int          checks = 0;

    pic_core dut (
        .clk_in           (clk_in),
        .rst_in           (rst_in),
        .intr_rq          (intr_rq),
        .intr_mode        (intr_mode),
        .priorities_table (priorities_table),
        .intr_in          (intr_in),
        .intr_ack_bus     (intr_ack_bus),
        .intr_out         (intr_out),
        .intr_bus         (intr_bus)
    );

    always #20 clk_in = ~clk_in;    // 40 ns period.

    ////////////////////
    // Models.
    ////////////////////

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Polling: first requester above the last one served, with wrap.
    function automatic src_id_t next_poll(input src_vec_t rq, input src_id_t last);
        src_id_t cand;
        src_id_t pick;
        bit      found;
        int      j;
        pick  = last;
        found = 1'b0;
        for (j = 1; j <= 8; j++) begin
            cand = src_id_t'(last + j);
            if (!found && rq[cand]) begin
                pick  = cand;
                found = 1'b1;
            end
        end
        return pick;
    endfunction

    // Priority: lowest table entry whose source requests.
    function automatic src_id_t rank_pick(input src_vec_t rq, input prio_table_t ranks);
        src_id_t pick;
        bit      found;
        int      r;
        pick  = '0;
        found = 1'b0;
        for (r = 0; r < 8; r++) begin
            if (!found && rq[ranks[r]]) begin
                pick  = ranks[r];
                found = 1'b1;
            end
        end
        return pick;
    endfunction

    ////////////////////
    // Helpers.
    ////////////////////

    task automatic compare_value(input string name, input logic [7:0] expected,
                                 input logic [7:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error at %0t: %s expected 'h%h, actual 'h%h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk_in);
        rst_in <= 1'b1;
        repeat (8) begin
            @(negedge clk_in);
            compare_value("intr_out", 8'h00, 8'(intr_out)); // Quiet while in reset.
            compare_value("intr_bus", 8'h00, intr_bus);
        end
        @(posedge clk_in);
        rst_in <= 1'b0;
    endtask

    task automatic wait_for_intr_out(output bit seen);
        int n;
        seen = 1'b0;
        for (n = 0; n < 40 && !seen; n++) begin
            @(negedge clk_in);
            seen = (intr_out === 1'b1);
        end
        if (!seen) begin
            errors++;
            $display("Timeout at %0t: intr_out did not rise within 40 cycles", $time);
        end
    endtask

    task automatic strobe_intr_in();
        @(posedge clk_in);
        intr_in <= 1'b0;    // Sampled low at the next edge only.
        @(posedge clk_in);
        intr_in <= 1'b1;
    endtask

    // First two handshake steps, returns the word read from intr_bus.
    task automatic begin_service(output intr_word_t word, output bit ok);
        wait_for_intr_out(ok);
        word = '0;
        if (ok) begin
            strobe_intr_in();
            @(negedge clk_in);
            compare_value("intr_out", 8'h00, 8'(intr_out)); // Dropped by the first low.
            word = intr_bus;
            strobe_intr_in();                               // Word acknowledge.
        end
    endtask

    task automatic send_done(input intr_word_t word, input bit drop);
        @(posedge clk_in);
        intr_in      <= 1'b0;
        intr_ack_bus <= word;
        if (drop) begin
            intr_rq <= intr_rq & ~(src_vec_t'(1) << word.id); // Request ends with service.
        end
        @(posedge clk_in);
        intr_in      <= 1'b1;
        intr_ack_bus <= '0;
    endtask

    task automatic serve_interrupt(input cond_code_t done, output intr_word_t word,
                                   output bit ok);
        begin_service(word, ok);
        if (ok) begin
            send_done(intr_word_t'{code: done, id: word.id}, 1'b1);
        end
    endtask

    ////////////////////
    // Tests.
    ////////////////////

    // No service without a captured mode.
    task automatic reset_state_test();
        int n;
        @(posedge clk_in);
        intr_rq   <= '1;
        intr_mode <= MODE_NONE;
        apply_reset();
        for (n = 0; n < 20; n++) begin
            @(posedge clk_in);
            if (n == 10) begin
                intr_mode <= MODE_BAD;  // Invalid code, still no capture.
            end
            @(negedge clk_in);
            compare_value("intr_out", 8'h00, 8'(intr_out));
            compare_value("intr_bus", 8'h00, intr_bus);
        end
    endtask

    task automatic poll_service_test();
        logic [31:0] r;
        src_id_t     k;
        intr_word_t  word;
        bit          ok;
        r = next_random();
        k = r[18:16];
        @(posedge clk_in);
        intr_mode <= MODE_POLL;
        intr_rq   <= src_vec_t'(1) << k;
        serve_interrupt(`PIC_CODE_POLL_DONE, word, ok);
        if (!ok) begin
            return;
        end
        compare_value("intr_bus", {`PIC_CODE_POLL_TX, k}, word);
        repeat (5) begin
            @(negedge clk_in);
            compare_value("intr_out", 8'h00, 8'(intr_out));          // Nothing left to serve.
            compare_value("intr_bus", {`PIC_CODE_POLL_TX, k}, intr_bus); // Last word stays.
        end
    endtask

    task automatic poll_order_test();
        logic [31:0] r;
        src_vec_t    remaining;
        src_id_t     last;
        intr_word_t  word;
        bit          ok;
        int          p;
        int          n;
        @(posedge clk_in);
        intr_rq <= '0;
        apply_reset();              // Polling is captured again, index back at 0.
        last = 3'd7;                // Scanning starts one above this source.
        for (p = 0; p < 2; p++) begin
            if (p > 0) begin
                repeat (3) @(posedge clk_in);   // Idle misses move the index on.
                last = src_id_t'(last + 3);
            end
            r = next_random();
            remaining = r[23:16] | 8'h81;   // Sources 0 and 7 force a wrap.
            @(posedge clk_in);
            intr_rq <= remaining;
            for (n = 0; n < 8 && remaining != '0; n++) begin
                serve_interrupt(`PIC_CODE_POLL_DONE, word, ok);
                if (!ok) begin
                    return;
                end
                compare_value("intr_bus",
                              {`PIC_CODE_POLL_TX, next_poll(remaining, last)}, word);
                remaining[word.id] = 1'b0;
                last = word.id;
            end
        end
    endtask

    task automatic prio_order_test();
        logic [31:0] r;
        src_vec_t    remaining;
        intr_word_t  word;
        bit          ok;
        int          perm [8];
        int          i;
        int          j;
        int          t;
        int          n;
        for (i = 0; i < 8; i++) begin
            perm[i] = i;
        end
        for (i = 7; i > 0; i--) begin   // Fisher-Yates shuffle.
            r = next_random();
            j = int'(r[30:8] % (i + 1));
            t = perm[i];
            perm[i] = perm[j];
            perm[j] = t;
        end
        for (i = 0; i < 8; i++) begin
            tbl[i] = src_id_t'(perm[i]);
        end
        @(posedge clk_in);
        intr_rq          <= '0;
        intr_mode        <= MODE_PRIO;
        priorities_table <= tbl;
        apply_reset();
        repeat (4) @(posedge clk_in);
        priorities_table <= ~tbl;       // Captured already, must be ignored.
        for (n = 0; n < 3; n++) begin
            r = next_random();
            remaining = r[15:8];
            if (remaining == '0) begin
                remaining = 8'h5a;
            end
            @(posedge clk_in);
            intr_rq <= remaining;
            for (i = 0; i < 8 && remaining != '0; i++) begin
                serve_interrupt(`PIC_CODE_PRIO_DONE, word, ok);
                if (!ok) begin
                    return;
                end
                compare_value("intr_bus",
                              {`PIC_CODE_PRIO_TX, rank_pick(remaining, tbl)}, word);
                remaining[word.id] = 1'b0;
            end
        end
    endtask

    // Wrong done words keep the controller in its wait.
    task automatic bad_done_test();
        logic [31:0] r;
        src_id_t     a;
        src_id_t     b;
        src_vec_t    rq;
        src_id_t     first;
        intr_word_t  word;
        bit          ok;
        r  = next_random();
        a  = r[18:16];
        b  = src_id_t'(a + 1 + (r[26:24] % 7));  // Always differs from a.
        rq = (src_vec_t'(1) << a) | (src_vec_t'(1) << b);
        first = rank_pick(rq, tbl);
        @(posedge clk_in);
        intr_rq <= rq;
        begin_service(word, ok);
        if (!ok) begin
            return;
        end
        compare_value("intr_bus", {`PIC_CODE_PRIO_TX, first}, word);
        send_done(intr_word_t'{code: `PIC_CODE_POLL_DONE, id: word.id}, 1'b0); // Wrong code.
        send_done(intr_word_t'{code: `PIC_CODE_PRIO_DONE, id: word.id ^ 3'd1}, 1'b0);
        repeat (10) begin
            @(negedge clk_in);
            compare_value("intr_out", 8'h00, 8'(intr_out));
        end
        send_done(intr_word_t'{code: `PIC_CODE_PRIO_DONE, id: word.id}, 1'b1);
        serve_interrupt(`PIC_CODE_PRIO_DONE, word, ok);
        if (ok) begin
            compare_value("intr_bus", {`PIC_CODE_PRIO_TX, (first == a) ? b : a}, word);
        end
    endtask

    initial begin
        clk_in           = 1'b0;
        rst_in           = 1'b1;
        intr_rq          = '0;
        intr_mode        = MODE_NONE;
        priorities_table = '0;
        intr_in          = 1'b1;
        intr_ack_bus     = '0;
        tbl              = '0;
        reset_state_test();
        poll_service_test();
        poll_order_test();
        prio_order_test();
        bad_done_test();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
